//--- files.f
hw/aes_key_pkg.sv
hw/aes_sbox_lut.sv
hw/aes_rcon_gen.sv
hw/aes_key_irregular.sv
hw/aes_key_regular.sv
hw/aes_key_expand.sv
tb/aes_key_expand_chk.sv
tb/aes_key_expand_tb.sv

//--- hw/aes_key_expand.sv
/*
 * AES round-key expansion unit, AES-128 and AES-256
 * Rcon generator plus combinational irregular and regular paths
 */

`timescale 1ns/1ps

module aes_key_expand
  import aes_key_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ciph_op_e   op_i,
  input  key_len_e   key_len_i,
  input  logic [3:0] round_i,
  input  logic       clear_i,
  input  logic       step_i,
  input  key_state_t key_i,
  output key_state_t key_o
);

  logic [7:0] rcon;
  logic       use_rcon;
  key_word_u  irregular;

  // Only stateful part, advances when the cipher takes key_o
  aes_rcon_gen u_rcon_gen (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .op_i       ( op_i      ),
    .key_len_i  ( key_len_i ),
    .round_i    ( round_i   ),
    .clear_i    ( clear_i   ),
    .step_i     ( step_i    ),
    .rcon_o     ( rcon      ),
    .use_rcon_o ( use_rcon  )
  );

  // RotWord, SubWord and Rcon
  aes_key_irregular u_irregular (
    .key_i       ( key_i     ),
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .rcon_i      ( rcon      ),
    .use_rcon_i  ( use_rcon  ),
    .irregular_o ( irregular )
  );

  // XOR chains, result goes straight back to the cipher
  aes_key_regular u_regular (
    .key_i       ( key_i     ),
    .irregular_i ( irregular ),
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .key_o       ( key_o     )
  );

endmodule

//--- hw/aes_key_irregular.sv
/*
 * Irregular part of the key schedule
 * RotWord source select, RotWord, SubWord over four S-Boxes, Rcon add
 */

`timescale 1ns/1ps

module aes_key_irregular
  import aes_key_pkg::*;
(
  input  key_state_t key_i,
  input  ciph_op_e   op_i,
  input  key_len_e   key_len_i,
  input  logic [3:0] round_i,
  input  logic [7:0] rcon_i,
  input  logic       use_rcon_i,
  output key_word_u  irregular_o
);

  key_word_u       spec_in_128;
  key_word_u       rot_in;
  key_word_u       rot_out;
  key_word_u       sub_in;
  logic [3:0][7:0] sub_out;
  logic            use_rot;

  ////////////////////////////////////////////////////////////
  // RotWord
  ////////////////////////////////////////////////////////////

  // AES-128 inverse needs the previous last word, rebuilt from words 3 and 2
  assign spec_in_128.word = key_i[3].word ^ key_i[2].word;

  always_comb begin : rot_src
    unique case (key_len_i)
      AES_128: begin
        // Forward takes the last word, inverse the rebuilt one
        rot_in = (op_i == CIPH_FWD) ? key_i[3] : spec_in_128;
      end
      AES_256: begin
        // Forward works off the upper half, inverse off the lower half
        rot_in = (op_i == CIPH_FWD) ? key_i[7] : key_i[3];
      end
      default: begin
        rot_in = key_i[3];
      end
    endcase
  end

  assign rot_out = rot_word(rot_in);

  // AES-256 even rounds skip the rotation
  assign use_rot = !((key_len_i == AES_256) && !round_i[0]);

  assign sub_in = use_rot ? rot_out : rot_in;

  ////////////////////////////////////////////////////////////
  // SubWord
  ////////////////////////////////////////////////////////////

  // One S-Box per byte
  for (genvar b = 0; b < 4; b++) begin : gen_sbox
    aes_sbox_lut u_sbox (
      .data_i ( sub_in.bytes[b] ),
      .data_o ( sub_out[b]      )
    );
  end

  ////////////////////////////////////////////////////////////
  // Rcon add
  ////////////////////////////////////////////////////////////

  always_comb begin : rcon_add
    irregular_o.bytes = sub_out;
    // Rcon only ever lands on the first byte
    if (use_rcon_i) begin
      irregular_o.bytes[0] = sub_out[0] ^ rcon_i;
    end
  end

endmodule

//--- hw/aes_key_pkg.sv
/*
 * Shared types and constants for the AES key expansion unit
 * Direction and key length enums, key word union and key state
 * Rcon start values, round counts, GF(2^8) and RotWord helpers
 */

package aes_key_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Key schedule direction
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  // One key word, whole for XOR chains or bytewise for RotWord/SubWord
  // Byte 0 is the first byte of the word in FIPS-197 order
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } key_word_u;

  // Full 256-bit key state, word 0 lowest
  typedef key_word_u [7:0] key_state_t;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // Rcon start values per direction and key length
  localparam logic [7:0] RconFwdInit    = 8'h01;
  localparam logic [7:0] RconInv128Init = 8'h36;
  localparam logic [7:0] RconInv256Init = 8'h40;

  // Rounds per key length
  localparam logic [3:0] NumRounds128 = 4'd10;
  localparam logic [3:0] NumRounds256 = 4'd14;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul2(logic [7:0] in);
    return {in[6:0], 1'b0} ^ (in[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x, the inverse of gf_mul2
  function automatic logic [7:0] gf_div2(logic [7:0] in);
    return {1'b0, in[7:1]} ^ (in[0] ? 8'h8d : 8'h00);
  endfunction

  // RotWord: byte 1 moves to byte 0, byte 0 wraps to byte 3
  function automatic key_word_u rot_word(key_word_u in);
    key_word_u out;
    out.bytes = {in.bytes[0], in.bytes[3:1]};
    return out;
  endfunction

endpackage

//--- hw/aes_key_regular.sv
/*
 * Regular part of the key schedule
 * XOR chains and half shifts for AES-128 and AES-256, forward and inverse
 */

`timescale 1ns/1ps

module aes_key_regular
  import aes_key_pkg::*;
(
  input  key_state_t key_i,
  input  key_word_u  irregular_i,
  input  ciph_op_e   op_i,
  input  key_len_e   key_len_i,
  input  logic [3:0] round_i,
  output key_state_t key_o
);

  key_state_t next_key;

  always_comb begin : regular_next
    // Hold everything unless a case below says otherwise
    next_key = key_i;

    unique case (key_len_i)

      ////////////////////////////////////////////////////////
      // AES-128
      ////////////////////////////////////////////////////////
      AES_128: begin
        // Upper words unused, park the old low words there
        next_key[7:4] = key_i[3:0];
        // First word always mixes in the irregular word
        next_key[0].word = irregular_i.word ^ key_i[0].word;
        unique case (op_i)
          CIPH_FWD: begin
            // Running chain over the fresh words
            for (int i = 1; i < 4; i++) begin
              next_key[i].word = next_key[i-1].word ^ key_i[i].word;
            end
          end
          CIPH_INV: begin
            // Neighbouring old words undo the chain
            for (int i = 1; i < 4; i++) begin
              next_key[i].word = key_i[i-1].word ^ key_i[i].word;
            end
          end
          default: begin
            next_key = key_i;
          end
        endcase
      end

      ////////////////////////////////////////////////////////
      // AES-256
      ////////////////////////////////////////////////////////
      AES_256: begin
        if (round_i == 4'd0) begin
          // Round 0 just uses the loaded key, state passes through
          next_key = key_i;
        end else begin
          unique case (op_i)
            CIPH_FWD: begin
              // Old upper half moves down
              next_key[3:0] = key_i[7:4];
              // New upper half from the irregular word and old lower half
              next_key[4].word = irregular_i.word ^ key_i[0].word;
              for (int i = 1; i < 4; i++) begin
                next_key[i+4].word = next_key[i+3].word ^ key_i[i].word;
              end
            end
            CIPH_INV: begin
              // Old lower half moves up
              next_key[7:4] = key_i[3:0];
              // Recover the previous lower half
              next_key[0].word = irregular_i.word ^ key_i[4].word;
              for (int i = 0; i < 3; i++) begin
                next_key[i+1].word = key_i[i+4].word ^ key_i[i+5].word;
              end
            end
            default: begin
              next_key = key_i;
            end
          endcase
        end
      end

      default: begin
        next_key = key_i;
      end
    endcase
  end

  assign key_o = next_key;

endmodule

//--- hw/aes_rcon_gen.sv
/*
 * Round constant generator for the key expansion
 * Holds Rcon, loads the start value on clear, doubles or halves on step
 * Also decides whether the current round consumes Rcon
 */

`timescale 1ns/1ps

module aes_rcon_gen
  import aes_key_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ciph_op_e   op_i,
  input  key_len_e   key_len_i,
  input  logic [3:0] round_i,
  input  logic       clear_i,
  input  logic       step_i,
  output logic [7:0] rcon_o,
  output logic       use_rcon_o
);

  logic [7:0] rcon_init;
  logic [7:0] rcon_d, rcon_q;
  logic       use_rcon;
  logic       rcon_we;

  // AES-256 even rounds only run SubWord, no Rcon
  assign use_rcon = !((key_len_i == AES_256) && !round_i[0]);

  // Start value depends on direction, and on key length when walking back
  always_comb begin : rcon_start
    if (op_i == CIPH_FWD) begin
      rcon_init = RconFwdInit;
    end else if (key_len_i == AES_128) begin
      rcon_init = RconInv128Init;
    end else begin
      rcon_init = RconInv256Init;
    end
  end

  // Next value, clear wins over step
  always_comb begin : rcon_next
    if (clear_i) begin
      rcon_d = rcon_init;
    end else if (op_i == CIPH_FWD) begin
      rcon_d = gf_mul2(rcon_q);
    end else begin
      rcon_d = gf_div2(rcon_q);
    end
  end

  // Only advance when the cipher takes a key that used Rcon
  assign rcon_we = clear_i | (step_i & use_rcon);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o     = rcon_q;
  assign use_rcon_o = use_rcon;

endmodule

//--- hw/aes_sbox_lut.sv
/*
 * Forward AES S-Box, plain 256-entry lookup table
 */

`timescale 1ns/1ps

module aes_sbox_lut (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Forward substitution table, indexed by input byte
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Pure lookup, no state
  assign data_o = SBOX[data_i];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the AES key expansion testbench with Verilator and run it.
# Exits nonzero unless the pass line appears in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module aes_key_expand_tb -o sim_aes_key_expand \
  && ./obj_dir/sim_aes_key_expand | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

exit 0

//--- tb/aes_key_expand_chk.sv
/*
 * Bound checks on the Rcon register of the key expansion
 * Start value after clear, hold while idle, no zero Rcon in forward runs
 */

`timescale 1ns/1ps

module aes_key_expand_chk
  import aes_key_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input ciph_op_e   op_i,
  input key_len_e   key_len_i,
  input logic       clear_i,
  input logic       step_i,
  input logic [7:0] rcon_i
);

  logic [7:0] init_exp;
  logic       fwd_run_q;

  // First Rcon forward, last used Rcon walking back (Rcon[10] or Rcon[7])
  always_comb begin : init_sel
    if (op_i == CIPH_FWD) begin
      init_exp = 8'h01;
    end else if (key_len_i == AES_128) begin
      init_exp = 8'h36;
    end else begin
      init_exp = 8'h40;
    end
  end

  // Set by a forward clear, dropped by an inverse one
  always_ff @(posedge clk_i or negedge rst_ni) begin : fwd_track
    if (!rst_ni) begin
      fwd_run_q <= 1'b0;
    end else if (clear_i) begin
      fwd_run_q <= (op_i == CIPH_FWD);
    end
  end

  rcon_after_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (rcon_i == $past(init_exp)))
    else $error("Rcon does not hold the start value one cycle after clear");

  rcon_hold_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!clear_i && !step_i) |=> $stable(rcon_i))
    else $error("Rcon changed in a cycle without clear or step");

  // Doubling in GF(2^8) never reaches zero from a nonzero start
  rcon_fwd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fwd_run_q |-> (rcon_i != 8'h00))
    else $error("Rcon became zero during a forward run");

endmodule

//--- tb/aes_key_expand_tb.sv
/*
 * Testbench for the AES key expansion unit
 * Clock and reset, FIPS-197 vector table, round stepping with random idle gaps
 * Final key checks, idle stability checks, per-test lines and summary
 */

`timescale 1ns/1ps

module aes_key_expand_tb
  import aes_key_pkg::*;
();

  localparam int          NumVecs       = 4;
  localparam int          ResetCycles   = 8;
  localparam int unsigned MaxIdle       = 3;
  localparam int          MaxTestCycles = 200;
  localparam int unsigned Seed          = 32'h3b32;

  logic       clk_i;
  logic       rst_ni;
  ciph_op_e   op_i;
  key_len_e   key_len_i;
  logic [3:0] round_i;
  logic       clear_i;
  logic       step_i;
  key_state_t key_i;
  key_state_t key_o;

  // Vector table with keys written w0 first as in FIPS-197
  string        vec_name   [NumVecs];
  key_len_e     vec_len    [NumVecs];
  ciph_op_e     vec_op     [NumVecs];
  logic [255:0] vec_start  [NumVecs];
  logic [255:0] vec_expect [NumVecs];

  int    errors;
  int    test_errors;
  int    test_cycles;
  int    passed;
  int    failed;
  bit    timeout_hit;
  string timeout_msg;

  ////////////////////////////////////////////////////////////
  // DUT, checker and clock
  ////////////////////////////////////////////////////////////

  aes_key_expand dut_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .round_i   ( round_i   ),
    .clear_i   ( clear_i   ),
    .step_i    ( step_i    ),
    .key_i     ( key_i     ),
    .key_o     ( key_o     )
  );

  // Rcon checks sit right on the register
  bind aes_rcon_gen aes_key_expand_chk u_chk (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .op_i      ( op_i      ),
    .key_len_i ( key_len_i ),
    .clear_i   ( clear_i   ),
    .step_i    ( step_i    ),
    .rcon_i    ( rcon_o    )
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // FIPS-197 writes the first byte leftmost
  // The key word keeps that byte in byte 0
  function automatic logic [31:0] swap_bytes(logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic key_state_t state_from_fips(logic [255:0] fips);
    key_state_t s;
    for (int i = 0; i < 8; i++) begin
      s[i].word = swap_bytes(fips[255-32*i -: 32]);
    end
    return s;
  endfunction

  task automatic compare_value(input string what, input logic [255:0] got,
                               input logic [255:0] expected);
    if (got !== expected) begin
      $display("Mismatch at %0d ns: %s, got %h, expected %h",
               $time, what, got, expected);
      test_errors++;
    end
  endtask

  task automatic set_vec(input int idx, input string name, input key_len_e len,
                         input ciph_op_e op, input logic [255:0] start,
                         input logic [255:0] expected);
    vec_name[idx]   = name;
    vec_len[idx]    = len;
    vec_op[idx]     = op;
    vec_start[idx]  = start;
    vec_expect[idx] = expected;
  endtask

  // FIPS-197 Appendix C keys
  // AES-128 results carry the previous round key in words 7..4
  // Inverse entries walk back from the last round keys
  task automatic load_table();
    set_vec(0, "aes128_fwd", AES_128, CIPH_FWD,
            {128'h00010203_04050607_08090a0b_0c0d0e0f, 128'h0},
            256'h13111d7f_e3944a17_f307a78b_4d2b30c5_549932d1_f0855768_1093ed9c_be2c974e);
    set_vec(1, "aes128_inv", AES_128, CIPH_INV,
            {128'h13111d7f_e3944a17_f307a78b_4d2b30c5, 128'h0},
            256'h00010203_04050607_08090a0b_0c0d0e0f_d6aa74fd_d2af72fa_daa678f1_d6ab76fe);
    set_vec(2, "aes256_fwd", AES_256, CIPH_FWD,
            256'h00010203_04050607_08090a0b_0c0d0e0f_10111213_14151617_18191a1b_1c1d1e1f,
            256'h4e5a6699_a9f24fe0_7e572baa_cdf8cdea_24fc79cc_bf0979e9_371ac23c_6d68de36);
    set_vec(3, "aes256_inv", AES_256, CIPH_INV,
            256'h4e5a6699_a9f24fe0_7e572baa_cdf8cdea_24fc79cc_bf0979e9_371ac23c_6d68de36,
            256'h00010203_04050607_08090a0b_0c0d0e0f_10111213_14151617_18191a1b_1c1d1e1f);
  endtask

  // One round is an idle gap with step_i low
  // and then the cycle in which the cipher takes key_o
  task automatic run_round(input logic [3:0] round, input int unsigned idle);
    key_state_t  held;
    key_state_t  taken;
    int unsigned waited;
    held    = '0;
    waited  = 0;
    round_i = round;
    while (waited < idle) begin
      if (waited >= MaxIdle) begin
        timeout_hit = 1'b1;
        timeout_msg = "idle gap did not end within its cycle limit";
        return;
      end
      @(negedge clk_i);
      // key_o must not move while nothing is taken
      if (waited == 0) begin
        held = key_o;
      end else begin
        compare_value($sformatf("key_o idle cycle %0d, round %0d", waited, round),
                      key_o, held);
      end
      @(posedge clk_i);
      #2;
      waited++;
      test_cycles++;
    end
    step_i = 1'b1;
    @(negedge clk_i);
    taken = key_o;
    if (idle > 0) begin
      compare_value($sformatf("key_o in step cycle, round %0d", round), taken, held);
    end
    // Key state register outside the unit loads key_o with the Rcon update
    @(posedge clk_i);
    #2;
    step_i = 1'b0;
    key_i  = taken;
    test_cycles++;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int unsigned idle;
    int          rounds;
    key_state_t  expected;
    void'($urandom(Seed));
    rst_ni      = 1'b0;
    op_i        = CIPH_FWD;
    key_len_i   = AES_128;
    round_i     = '0;
    clear_i     = 1'b0;
    step_i      = 1'b0;
    key_i       = '0;
    errors      = 0;
    passed      = 0;
    failed      = 0;
    timeout_hit = 1'b0;
    timeout_msg = "";
    load_table();

    for (int c = 0; c < ResetCycles; c++) begin
      @(posedge clk_i);
    end
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;

    for (int v = 0; v < NumVecs && !timeout_hit; v++) begin
      test_errors = 0;
      test_cycles = 0;
      rounds = (vec_len[v] == AES_128) ? int'(NumRounds128) : int'(NumRounds256);
      // Load start key and the initial Rcon in one clear cycle
      op_i      = vec_op[v];
      key_len_i = vec_len[v];
      round_i   = '0;
      key_i     = state_from_fips(vec_start[v]);
      clear_i   = 1'b1;
      @(posedge clk_i);
      #2;
      clear_i = 1'b0;
      for (int r = 0; r < rounds && !timeout_hit; r++) begin
        idle = $urandom_range(MaxIdle, 0);
        run_round(r[3:0], idle);
        if (test_cycles > MaxTestCycles) begin
          timeout_hit = 1'b1;
          timeout_msg = {"test ", vec_name[v], " ran past its cycle budget"};
        end
      end
      expected = state_from_fips(vec_expect[v]);
      compare_value({vec_name[v], " final key"}, key_i, expected);
      errors += test_errors;
      if (test_errors == 0 && !timeout_hit) begin
        passed++;
        $display("Test %0d %s: ok", v, vec_name[v]);
      end else begin
        failed++;
        $display("Test %0d %s: failed with %0d mismatches", v, vec_name[v], test_errors);
      end
    end

    if (timeout_hit) begin
      $display("Timeout: %s", timeout_msg);
    end
    $display("Summary: %0d tests passed, %0d failed, %0d mismatches", passed, failed, errors);
    if (errors == 0 && failed == 0 && !timeout_hit) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
